//--- common/pcs_shim_pkg.sv
`default_nettype none

package pcs_shim_pkg;

    // ************************************************************
    // Block geometry.
    // ************************************************************
    localparam int BLK_DWIDTH = 64;
    localparam int BLK_CWIDTH = 2;

    // Sync header codes. 00 and 11 are invalid on the line.
    localparam logic [BLK_CWIDTH-1:0] SYNC_DATA = 2'b10;
    localparam logic [BLK_CWIDTH-1:0] SYNC_CTRL = 2'b01;

    // ************************************************************
    // Control block payloads.
    // ************************************************************
    localparam logic [7:0] BLK_TYPE_CTRL = 8'h1e;
    localparam logic [6:0] CTRL_CODE_ERROR = 7'h1e;

    // All eight control codes are idle (zero).
    localparam logic [BLK_DWIDTH-1:0] IDLE_BLOCK = {56'h0, BLK_TYPE_CTRL};

    // All eight control codes carry the error code.
    localparam logic [BLK_DWIDTH-1:0] ERROR_BLOCK = {{8{CTRL_CODE_ERROR}}, BLK_TYPE_CTRL};

endpackage

`default_nettype wire

//--- hw/shim_block_check.sv
`timescale 1ns/1ps
`default_nettype none

module shim_block_check import pcs_shim_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  blk_valid,
    input  logic [BLK_DWIDTH-1:0] blk_data,
    input  logic [BLK_CWIDTH-1:0] blk_ctrl,
    output logic                  chk_valid,
    output logic [BLK_DWIDTH-1:0] chk_data,
    output logic [BLK_CWIDTH-1:0] chk_ctrl,
    output logic [31:0]           bad_hdr_count
);

    logic hdr_bad;

    // Only 01 and 10 are legal sync headers.
    assign hdr_bad = (blk_ctrl != SYNC_DATA) && (blk_ctrl != SYNC_CTRL);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            chk_valid <= 1'b0;
        end else begin
            chk_valid <= blk_valid;
        end
    end

    // Malformed blocks go out as an error control block.
    always_ff @(posedge clk) begin
        if (hdr_bad) begin
            chk_data <= ERROR_BLOCK;
            chk_ctrl <= SYNC_CTRL;
        end else begin
            chk_data <= blk_data;
            chk_ctrl <= blk_ctrl;
        end
    end

    // Saturating bad header count.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bad_hdr_count <= '0;
        end else if (blk_valid && hdr_bad && (bad_hdr_count != '1)) begin
            bad_hdr_count <= bad_hdr_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/shim_fifo/shim_fifo_buf.sv
`timescale 1ns/1ps
`default_nettype none

module shim_fifo_buf import pcs_shim_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rd,
    input  logic                  wr,
    input  logic [BLK_DWIDTH-1:0] w_data_d,
    input  logic [BLK_CWIDTH-1:0] w_data_c,
    output logic                  empty,
    output logic                  full,
    output logic [BLK_DWIDTH-1:0] r_data_d,
    output logic [BLK_CWIDTH-1:0] r_data_c
);

    localparam int ENTRIES = 2**DEPTH;

    logic [BLK_DWIDTH-1:0] darray [ENTRIES];
    logic [BLK_CWIDTH-1:0] carray [ENTRIES];

    logic [DEPTH-1:0] w_ptr;
    logic [DEPTH-1:0] w_ptr_next;
    logic [DEPTH-1:0] w_ptr_succ;
    logic [DEPTH-1:0] r_ptr;
    logic [DEPTH-1:0] r_ptr_next;
    logic [DEPTH-1:0] r_ptr_succ;

    logic full_reg;
    logic full_next;
    logic empty_reg;
    logic empty_next;

    logic wr_en;
    logic rd_en;

    // Writes to a full buffer and reads from an empty one are dropped.
    assign wr_en = wr & ~full_reg;
    assign rd_en = rd & ~empty_reg;

    assign w_ptr_succ = w_ptr + 1'b1;
    assign r_ptr_succ = r_ptr + 1'b1;

    // ************************************************************
    // Storage.
    // ************************************************************
    always_ff @(posedge clk) begin
        if (wr_en) begin
            darray[w_ptr] <= w_data_d;
            carray[w_ptr] <= w_data_c;
        end
    end

    // Idle block on the line whenever the head is not being taken.
    assign r_data_d = rd ? darray[r_ptr] : IDLE_BLOCK;
    assign r_data_c = rd ? carray[r_ptr] : SYNC_CTRL;

    // ************************************************************
    // Pointers and flags.
    // ************************************************************
    always_comb begin
        w_ptr_next = w_ptr;
        r_ptr_next = r_ptr;
        full_next  = full_reg;
        empty_next = empty_reg;

        case ({wr_en, rd_en})
            2'b01: begin
                r_ptr_next = r_ptr_succ;
                full_next  = 1'b0;
                if (r_ptr_succ == w_ptr) begin
                    empty_next = 1'b1;
                end
            end
            2'b10: begin
                w_ptr_next = w_ptr_succ;
                empty_next = 1'b0;
                if (w_ptr_succ == r_ptr) begin
                    full_next = 1'b1;
                end
            end
            2'b11: begin
                // Occupancy unchanged, so flags hold.
                w_ptr_next = w_ptr_succ;
                r_ptr_next = r_ptr_succ;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            w_ptr     <= '0;
            r_ptr     <= '0;
            full_reg  <= 1'b0;
            empty_reg <= 1'b1;
        end else begin
            w_ptr     <= w_ptr_next;
            r_ptr     <= r_ptr_next;
            full_reg  <= full_next;
            empty_reg <= empty_next;
        end
    end

    assign full  = full_reg;
    assign empty = empty_reg;

endmodule

`default_nettype wire

//--- hw/shim_fifo/shim_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module shim_read_ctrl #(
    parameter int DEPTH = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        line_slot,
    input  logic        empty,
    output logic        rd,
    output logic        credit_return,
    output logic [31:0] idle_count
);

    // Pop the head only on a line slot with data waiting.
    assign rd = line_slot & ~empty;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= rd;
        end
    end

    // Slots filled with IDLE, saturating.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idle_count <= '0;
        end else if (line_slot && empty && (idle_count != '1)) begin
            idle_count <= idle_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/pcs_tx_shim.sv
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_shim import pcs_shim_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  blk_valid,
    input  logic [BLK_DWIDTH-1:0] blk_data,
    input  logic [BLK_CWIDTH-1:0] blk_ctrl,
    input  logic                  line_slot,
    output logic                  credit_return,
    output logic [BLK_DWIDTH-1:0] out_data,
    output logic [BLK_CWIDTH-1:0] out_ctrl,
    output logic [31:0]           bad_hdr_count,
    output logic [31:0]           idle_count
);

    logic                  chk_valid;
    logic [BLK_DWIDTH-1:0] chk_data;
    logic [BLK_CWIDTH-1:0] chk_ctrl;

    logic fifo_empty;
    logic fifo_full;
    logic fifo_rd;

    // ************************************************************
    // Header check, one cycle.
    // ************************************************************
    shim_block_check check_i (
        .clk           (clk),
        .reset         (reset),
        .blk_valid     (blk_valid),
        .blk_data      (blk_data),
        .blk_ctrl      (blk_ctrl),
        .chk_valid     (chk_valid),
        .chk_data      (chk_data),
        .chk_ctrl      (chk_ctrl),
        .bad_hdr_count (bad_hdr_count)
    );

    // ************************************************************
    // Block buffer and line-side scheduling.
    // ************************************************************
    shim_fifo_buf #(
        .DEPTH (DEPTH)
    ) fifo_i (
        .clk      (clk),
        .reset    (reset),
        .rd       (fifo_rd),
        .wr       (chk_valid),
        .w_data_d (chk_data),
        .w_data_c (chk_ctrl),
        .empty    (fifo_empty),
        .full     (fifo_full),
        .r_data_d (out_data),
        .r_data_c (out_ctrl)
    );

    shim_read_ctrl #(
        .DEPTH (DEPTH)
    ) read_ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .line_slot     (line_slot),
        .empty         (fifo_empty),
        .rd            (fifo_rd),
        .credit_return (credit_return),
        .idle_count    (idle_count)
    );

endmodule

`default_nettype wire

//--- dv/pcs_tx_shim_chk.sv
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_shim_chk #(
    parameter int DEPTH = 4
) (
    input logic             clk,
    input logic             reset,
    input logic             wr,
    input logic             empty,
    input logic             full,
    input logic [DEPTH-1:0] r_ptr,
    input logic             credit_return
);

    // ************************************************************
    // Credit discipline.
    // ************************************************************
    no_write_when_full: assert property (
        @(posedge clk) disable iff (reset) !(wr && full)
    ) else $error("FIFO written while full, block dropped");

    // A pop is seen as the read pointer moving on.
    credit_after_pop: assert property (
        @(posedge clk) disable iff (reset) credit_return |-> (r_ptr != $past(r_ptr))
    ) else $error("credit_return without a pop in the previous cycle");

    // ************************************************************
    // Reset state.
    // ************************************************************
    quiet_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> (!credit_return && !wr)
    ) else $error("credit_return or FIFO write active right after reset");

    flags_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> (empty && !full)
    ) else $error("FIFO flags wrong right after reset");

endmodule

bind pcs_tx_shim pcs_tx_shim_chk #(
    .DEPTH (DEPTH)
) chk_i (
    .clk           (clk),
    .reset         (reset),
    .wr            (chk_valid),
    .empty         (fifo_empty),
    .full          (fifo_full),
    .r_ptr         (fifo_i.r_ptr),
    .credit_return (credit_return)
);

`default_nettype wire

//--- dv/pcs_tx_shim_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_shim_tb import pcs_shim_pkg::*; ();

    localparam int DEPTH       = 4;
    localparam int CREDITS     = 2**DEPTH;
    localparam int DRAIN_LIMIT = 400;

    logic                  clk;
    logic                  reset;
    logic                  blk_valid;
    logic [BLK_DWIDTH-1:0] blk_data;
    logic [BLK_CWIDTH-1:0] blk_ctrl;
    logic                  line_slot;
    logic                  credit_return;
    logic [BLK_DWIDTH-1:0] out_data;
    logic [BLK_CWIDTH-1:0] out_ctrl;
    logic [31:0]           bad_hdr_count;
    logic [31:0]           idle_count;

    // Source side bookkeeping.
    int    cyc = 0;
    int    credits;
    int    sent;
    int    pulses;
    int    bad_sent;
    int    exp_idle;
    int    checks;
    int    errors;
    string test_name;

    logic [BLK_CWIDTH+BLK_DWIDTH-1:0] exp_q [$];
    int                               exp_cyc_q [$];

    pcs_tx_shim #(
        .DEPTH (DEPTH)
    ) dut_i (
        .clk           (clk),
        .reset         (reset),
        .blk_valid     (blk_valid),
        .blk_data      (blk_data),
        .blk_ctrl      (blk_ctrl),
        .line_slot     (line_slot),
        .credit_return (credit_return),
        .out_data      (out_data),
        .out_ctrl      (out_ctrl),
        .bad_hdr_count (bad_hdr_count),
        .idle_count    (idle_count)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ************************************************************
    // Reference model and checks.
    // ************************************************************
    function automatic logic [BLK_CWIDTH+BLK_DWIDTH-1:0] ref_block(
        input logic [BLK_DWIDTH-1:0] data,
        input logic [BLK_CWIDTH-1:0] hdr
    );
        if (hdr == SYNC_DATA || hdr == SYNC_CTRL) begin
            return {hdr, data};
        end
        return {SYNC_CTRL, ERROR_BLOCK};
    endfunction

    task automatic check_value(input string name, input logic [65:0] expected,
                               input logic [65:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Blocks become eligible two cycles after they were driven.
    always @(negedge clk) begin
        if (!reset && line_slot) begin
            if (exp_q.size() > 0 && (cyc - exp_cyc_q[0]) >= 2) begin
                check_value({test_name, " data"}, exp_q.pop_front(), {out_ctrl, out_data});
                void'(exp_cyc_q.pop_front());
            end else begin
                exp_idle++;
                check_value({test_name, " idle"}, {SYNC_CTRL, IDLE_BLOCK}, {out_ctrl, out_data});
            end
        end
    end

    // ************************************************************
    // Stimulus.
    // ************************************************************
    task automatic drive_cycle(input bit want_send, input int slot_pct);
        logic [BLK_DWIDTH-1:0] data;
        logic [BLK_CWIDTH-1:0] hdr;
        @(posedge clk);
        #1;
        if (credit_return) begin
            credits++;
            pulses++;
        end
        blk_valid = 1'b0;
        if (want_send && credits > 0) begin
            data = {$urandom, $urandom};
            if ($urandom_range(7) == 0) begin
                hdr = $urandom_range(1) ? 2'b11 : 2'b00;
                bad_sent++;
            end else begin
                hdr = $urandom_range(1) ? SYNC_DATA : SYNC_CTRL;
            end
            blk_valid = 1'b1;
            blk_data  = data;
            blk_ctrl  = hdr;
            exp_q.push_back(ref_block(data, hdr));
            exp_cyc_q.push_back(cyc);
            credits--;
            sent++;
        end
        line_slot = ($urandom_range(99) < slot_pct);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset     = 1'b1;
        blk_valid = 1'b0;
        line_slot = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        exp_q.delete();
        exp_cyc_q.delete();
        credits  = CREDITS;
        sent     = 0;
        pulses   = 0;
        bad_sent = 0;
        exp_idle = 0;
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // The last credit pulse lands one cycle after the last pop.
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            drive_cycle(1'b0, 100);
            waited++;
        end
        if (waited >= DRAIN_LIMIT) begin
            $display("Timeout in %s: %0d blocks never left the shim", test_name, exp_q.size());
            errors++;
            finish_run();
        end else begin
            drive_cycle(1'b0, 0);
        end
    endtask

    task automatic check_counters();
        check_value({test_name, " idle_count"}, exp_idle, idle_count);
        check_value({test_name, " bad_hdr_count"}, bad_sent, bad_hdr_count);
        check_value({test_name, " credit pulses"}, sent, pulses);
        check_value({test_name, " credit balance"}, CREDITS, credits);
    endtask

    // Fill with line slots off until the source has no credit left.
    task automatic fill_until_stalled();
        int waited;
        int start;
        start  = sent;
        waited = 0;
        while (credits > 0 && waited < 3 * CREDITS) begin
            drive_cycle(1'b1, 0);
            waited++;
        end
        repeat (5) drive_cycle(1'b1, 0);
        check_value({test_name, " blocks accepted"}, CREDITS, sent - start);
    endtask

    initial begin
        void'($urandom(13218));
        reset     = 1'b1;
        blk_valid = 1'b0;
        blk_data  = '0;
        blk_ctrl  = SYNC_CTRL;
        line_slot = 1'b0;
        checks    = 0;
        errors    = 0;
        test_name = "mixed";
        apply_reset();

        for (int i = 0; i < 300; i++) begin
            drive_cycle($urandom_range(9) < 7, 60);
        end
        drain();
        check_counters();

        test_name = "back_pressure";
        fill_until_stalled();
        drain();
        check_counters();

        test_name = "reset";
        for (int i = 0; i < 20; i++) begin
            drive_cycle(1'b1, 30);
        end
        apply_reset();
        check_value("reset idle_count zero", 0, idle_count);
        check_value("reset bad_hdr_count zero", 0, bad_hdr_count);
        drive_cycle(1'b0, 100);
        drive_cycle(1'b0, 0);
        check_value("reset first slot idle", 1, idle_count);
        fill_until_stalled();
        drain();
        check_counters();

        finish_run();
    end

endmodule

`default_nettype wire

//--- build.f
common/pcs_shim_pkg.sv
hw/shim_block_check.sv
hw/shim_fifo/shim_fifo_buf.sv
hw/shim_fifo/shim_read_ctrl.sv
hw/pcs_tx_shim.sv
dv/pcs_tx_shim_chk.sv
dv/pcs_tx_shim_tb.sv

//--- Bender.yml
package:
  name: pcs_tx_shim

sources:
  - common/pcs_shim_pkg.sv
  - hw/shim_block_check.sv
  - hw/shim_fifo/shim_fifo_buf.sv
  - hw/shim_fifo/shim_read_ctrl.sv
  - hw/pcs_tx_shim.sv
  - target: simulation
    files:
      - dv/pcs_tx_shim_chk.sv
      - dv/pcs_tx_shim_tb.sv
